//--- sim.f
+incdir+include
hdl/udp_hdr_pkg.sv
hdl/echo_stream_pkg.sv
hdl/udp_port_filter.sv
hdl/payload_fifo.sv
hdl/echo_reply_tx.sv
hdl/udp_echo_core.sv
bench/udp_echo_tb.sv

//--- Makefile
# Verilator build and run of the UDP echo core testbench

VERILATOR ?= verilator
TOP       ?= udp_echo_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Pass only when the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/udp_echo_tb.sv
//////////////////////////////////////////////////////////////////////
// Random UDP datagrams checked against a reference model of the core
// The stalled burst assumes kept payload can outgrow the FIFO depth
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_macros.svh"

module udp_echo_tb;

    localparam int WAIT_LIMIT    = 2000;
    localparam int STALL_CYCLES  = 300;
    localparam int RANDOM_FRAMES = 80;
    localparam int BURST_FRAMES  = `PAYLOAD_FIFO_DEPTH / 16 + 4;

    // 192.168.1.128
    localparam udp_hdr_pkg::ip_addr_t LOCAL_IP_ADDR = 32'hc0a8_0180;
    localparam udp_hdr_pkg::ttl_t     REPLY_TTL_VAL = 8'd64;

    logic                           clk;
    logic                           rst;
    udp_hdr_pkg::udp_rx_hdr_t       rx_hdr;
    logic                           rx_hdr_valid;
    logic                           rx_hdr_ready;
    echo_stream_pkg::payload_beat_t rx_pay;
    logic                           rx_pay_valid;
    logic                           rx_pay_ready;
    udp_hdr_pkg::udp_tx_hdr_t       tx_hdr;
    logic                           tx_hdr_valid;
    logic                           tx_hdr_ready;
    echo_stream_pkg::payload_beat_t tx_pay;
    logic                           tx_pay_valid;
    logic                           tx_pay_ready;
    echo_stream_pkg::byte_t         led;

    logic [31:0]                    lfsr;
    logic [31:0]                    sink_lfsr;
    logic                           pay_stall;
    logic                           first_out;
    echo_stream_pkg::byte_t         led_model;
    echo_stream_pkg::payload_beat_t seen_beat;
    int                             hdr_errors;
    int                             beat_errors;
    int                             led_errors;
    int                             misc_errors;
    int                             timeout_count;
    int                             tx_beat_count;
    int                             exp_beat_total;
    int                             full_cycles;

    // Reference model queues
    udp_hdr_pkg::udp_tx_hdr_t       exp_hdr_q[$];
    echo_stream_pkg::payload_beat_t exp_beat_q[$];
    echo_stream_pkg::byte_t         exp_led_q[$];

    udp_echo_core uut (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_pay       (rx_pay),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_ready (rx_pay_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_pay       (tx_pay),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready),
        .led          (led)
    );

    always #5 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit(inout logic [31:0] state);
        logic out;
        out   = state[0];
        state = state >> 1;
        if (out) begin
            state = state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          j;
        v = '0;
        for (j = 0; j < n; j++) begin
            v = {v[30:0], next_bit(lfsr)};
        end
        return v;
    endfunction

    task automatic check_hdr(input udp_hdr_pkg::udp_tx_hdr_t got,
                             input udp_hdr_pkg::udp_tx_hdr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t tx_hdr got %h expected %h", $time, got, exp);
            hdr_errors++;
        end
    endtask

    task automatic check_beat(input echo_stream_pkg::payload_beat_t got,
                              input echo_stream_pkg::payload_beat_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t tx_pay got %h expected %h", $time, got, exp);
            beat_errors++;
        end
    endtask

    task automatic check_led(input echo_stream_pkg::byte_t got,
                             input echo_stream_pkg::byte_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t led got %h expected %h", $time, got, exp);
            led_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            misc_errors++;
        end
    endtask

    task automatic wait_hdr_taken();
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
            taken = rx_hdr_ready;
        end
        if (!taken) begin
            $display("Timeout at %0t: receive header was never accepted", $time);
            timeout_count++;
        end
    endtask

    task automatic wait_beat_taken();
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
            taken = rx_pay_ready;
        end
        if (!taken) begin
            $display("Timeout at %0t: receive payload beat was never accepted", $time);
            timeout_count++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_hdr_q.size() > 0 || exp_beat_q.size() > 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_hdr_q.size() > 0 || exp_beat_q.size() > 0) begin
            $display("Timeout at %0t: %0d reply headers and %0d beats never came out",
                     $time, exp_hdr_q.size(), exp_beat_q.size());
            timeout_count++;
        end
    endtask

    // One datagram, fixed_len of 0 picks a random length
    task automatic send_datagram(input logic force_echo, input int fixed_len, input logic gaps);
        udp_hdr_pkg::udp_rx_hdr_t       h;
        udp_hdr_pkg::udp_tx_hdr_t       e;
        echo_stream_pkg::payload_beat_t b;
        logic [31:0]                    r;
        logic                           echo;
        int                             len;
        int                             i;
        int                             idle;
        h.src_ip   = rand_bits(32);
        h.dst_ip   = rand_bits(32);
        r          = rand_bits(16);
        h.src_port = r[15:0];
        r          = rand_bits(1);
        echo       = force_echo || r[0];
        if (echo) begin
            h.dst_port = `ECHO_PORT;
        end else begin
            r          = rand_bits(16);
            h.dst_port = (r[15:0] == `ECHO_PORT) ? r[15:0] + 16'd1 : r[15:0];
        end
        if (fixed_len > 0) begin
            len = fixed_len;
        end else begin
            r   = rand_bits(4);
            len = int'(r[3:0]) + 1;
        end
        h.length = 16'(len + 8);

        // Reply rule: ports swapped, own IP as source, sender as destination
        if (echo) begin
            e.src_ip   = LOCAL_IP_ADDR;
            e.dst_ip   = h.src_ip;
            e.ttl      = REPLY_TTL_VAL;
            e.src_port = h.dst_port;
            e.dst_port = h.src_port;
            e.length   = h.length;
            e.checksum = 16'h0000;
            exp_hdr_q.push_back(e);
        end

        rx_hdr       <= h;
        rx_hdr_valid <= 1'b1;
        wait_hdr_taken();
        rx_hdr_valid <= 1'b0;

        for (i = 0; i < len && timeout_count == 0; i++) begin
            r      = rand_bits(9);
            b.data = r[7:0];
            b.user = r[8];
            b.last = (i == len - 1);
            if (echo) begin
                exp_beat_q.push_back(b);
                exp_beat_total++;
                if (i == 0) begin
                    exp_led_q.push_back(b.data);
                end
            end
            if (gaps) begin
                r    = rand_bits(2);
                idle = int'(r[1:0]);
                if (idle > 0) begin
                    rx_pay_valid <= 1'b0;
                    repeat (idle) @(posedge clk);
                end
            end
            rx_pay       <= b;
            rx_pay_valid <= 1'b1;
            wait_beat_taken();
        end
        rx_pay_valid <= 1'b0;
    endtask

    // Random sink back-pressure, payload held off during the burst
    always @(posedge clk) begin
        tx_hdr_ready <= next_bit(sink_lfsr);
        tx_pay_ready <= pay_stall ? 1'b0 : next_bit(sink_lfsr);
    end

    // Output monitor, pre-edge values sampled on every rising edge
    always @(posedge clk) begin
        if (!rst) begin
            check_led(led, led_model);
            if (rx_pay_valid && !rx_pay_ready) begin
                full_cycles++;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    $display("Reply header at %0t with no matching datagram", $time);
                    misc_errors++;
                end else begin
                    check_hdr(tx_hdr, exp_hdr_q.pop_front());
                end
            end
            if (tx_pay_valid && tx_pay_ready) begin
                tx_beat_count++;
                if (exp_beat_q.size() == 0) begin
                    $display("Payload beat at %0t that no datagram accounts for", $time);
                    misc_errors++;
                end else begin
                    seen_beat = exp_beat_q.pop_front();
                    check_beat(tx_pay, seen_beat);
                    if (first_out && exp_led_q.size() > 0) begin
                        led_model = exp_led_q.pop_front();
                    end
                    first_out = seen_beat.last;
                end
            end
        end
    end

    initial begin
        int n;
        int k;
        clk            = 1'b0;
        rst            = 1'b1;
        rx_hdr         = '0;
        rx_hdr_valid   = 1'b0;
        rx_pay         = '0;
        rx_pay_valid   = 1'b0;
        tx_hdr_ready   = 1'b0;
        tx_pay_ready   = 1'b0;
        lfsr           = 32'hd6d4ec71;
        // Sink stream branches off the stimulus sequence
        sink_lfsr      = rand_bits(32);
        pay_stall      = 1'b0;
        first_out      = 1'b1;
        led_model      = '0;
        hdr_errors     = 0;
        beat_errors    = 0;
        led_errors     = 0;
        misc_errors    = 0;
        timeout_count  = 0;
        tx_beat_count  = 0;
        exp_beat_total = 0;
        full_cycles    = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // Idle outputs right after reset
        check_flag("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check_flag("tx_pay_valid", tx_pay_valid, 1'b0);
        check_led(led, 8'h00);

        for (n = 0; n < RANDOM_FRAMES && timeout_count == 0; n++) begin
            send_datagram(1'b0, 0, 1'b1);
        end

        // Kept frames back to back while the sink holds off
        pay_stall <= 1'b1;
        fork
            begin
                for (k = 0; k < BURST_FRAMES && timeout_count == 0; k++) begin
                    send_datagram(1'b1, 16, 1'b0);
                end
            end
            begin
                repeat (STALL_CYCLES) @(posedge clk);
                pay_stall <= 1'b0;
            end
        join

        if (timeout_count == 0) begin
            wait_drain();
        end
        repeat (4) @(posedge clk);

        if (tx_beat_count != exp_beat_total) begin
            $display("Transferred %0d payload beats but %0d were expected",
                     tx_beat_count, exp_beat_total);
            misc_errors++;
        end
        if (full_cycles == 0) begin
            $display("The FIFO never filled during the stalled burst");
            misc_errors++;
        end

        $display("Summary: hdr %0d, beat %0d, led %0d, other %0d errors, %0d timeouts, %0d beats",
                 hdr_errors, beat_errors, led_errors, misc_errors, timeout_count,
                 tx_beat_count);
        if (hdr_errors + beat_errors + led_errors + misc_errors + timeout_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/udp_echo_core.sv
//////////////////////////////////////////////////////////////////////
// UDP echo at parsed-frame level, header and payload are separate
// streams and each keeps frame order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_echo_core (
    input  logic                           clk,
    input  logic                           rst,

    input  udp_hdr_pkg::udp_rx_hdr_t       rx_hdr,
    input  logic                           rx_hdr_valid,
    output logic                           rx_hdr_ready,
    input  echo_stream_pkg::payload_beat_t rx_pay,
    input  logic                           rx_pay_valid,
    output logic                           rx_pay_ready,

    output udp_hdr_pkg::udp_tx_hdr_t       tx_hdr,
    output logic                           tx_hdr_valid,
    input  logic                           tx_hdr_ready,
    output echo_stream_pkg::payload_beat_t tx_pay,
    output logic                           tx_pay_valid,
    input  logic                           tx_pay_ready,

    output echo_stream_pkg::byte_t         led
);

    udp_hdr_pkg::udp_rx_hdr_t       keep_hdr;
    logic                           keep_hdr_valid;
    logic                           keep_hdr_ready;
    echo_stream_pkg::payload_beat_t keep_pay;
    logic                           keep_pay_valid;
    logic                           keep_pay_ready;

    udp_port_filter u_filter (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr         (rx_hdr),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_pay         (rx_pay),
        .rx_pay_valid   (rx_pay_valid),
        .rx_pay_ready   (rx_pay_ready),
        .keep_hdr       (keep_hdr),
        .keep_hdr_valid (keep_hdr_valid),
        .keep_hdr_ready (keep_hdr_ready),
        .keep_pay       (keep_pay),
        .keep_pay_valid (keep_pay_valid),
        .keep_pay_ready (keep_pay_ready)
    );

    payload_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (keep_pay),
        .in_valid  (keep_pay_valid),
        .in_ready  (keep_pay_ready),
        .out_beat  (tx_pay),
        .out_valid (tx_pay_valid),
        .out_ready (tx_pay_ready)
    );

    // Reply side also watches the outgoing payload for the LED byte
    echo_reply_tx u_reply (
        .clk          (clk),
        .rst          (rst),
        .req_hdr      (keep_hdr),
        .req_valid    (keep_hdr_valid),
        .req_ready    (keep_hdr_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_pay       (tx_pay),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready),
        .led          (led)
    );

endmodule

`default_nettype wire

//--- hdl/echo_reply_tx.sv
//////////////////////////////////////////////////////////////////////
// Single-slot reply header register and first-byte LED latch
// Checksum of replies is always zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_macros.svh"

module echo_reply_tx (
    input  logic                           clk,
    input  logic                           rst,

    input  udp_hdr_pkg::udp_rx_hdr_t       req_hdr,
    input  logic                           req_valid,
    output logic                           req_ready,

    output udp_hdr_pkg::udp_tx_hdr_t       tx_hdr,
    output logic                           tx_hdr_valid,
    input  logic                           tx_hdr_ready,

    input  echo_stream_pkg::payload_beat_t tx_pay,
    input  logic                           tx_pay_valid,
    input  logic                           tx_pay_ready,

    output echo_stream_pkg::byte_t         led
);

    logic first_beat;

    // Slot takes a new request only when empty
    assign req_ready = !tx_hdr_valid;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            tx_hdr.src_ip   <= `LOCAL_IP;
            tx_hdr.dst_ip   <= req_hdr.src_ip;
            tx_hdr.ttl      <= `REPLY_TTL;
            tx_hdr.src_port <= req_hdr.dst_port;
            tx_hdr.dst_port <= req_hdr.src_port;
            tx_hdr.length   <= req_hdr.length;
            tx_hdr.checksum <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Track frame starts on the outgoing payload
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (tx_pay_valid && tx_pay_ready) begin
            if (first_beat) begin
                led <= tx_pay.data;
            end
            first_beat <= tx_pay.last;
        end
    end

    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=> (tx_hdr_valid && $stable(tx_hdr))
    );

endmodule

`default_nettype wire

//--- hdl/payload_fifo.sv
//////////////////////////////////////////////////////////////////////
// FWFT FIFO of payload beats with a registered output stage
// DEPTH must be a power of two, one extra beat sits in the output reg
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_macros.svh"

module payload_fifo #(
    parameter int DEPTH = `PAYLOAD_FIFO_DEPTH
) (
    input  logic                           clk,
    input  logic                           rst,

    input  echo_stream_pkg::payload_beat_t in_beat,
    input  logic                           in_valid,
    output logic                           in_ready,

    output echo_stream_pkg::payload_beat_t out_beat,
    output logic                           out_valid,
    input  logic                           out_ready
);

    localparam int AW = $clog2(DEPTH);

    echo_stream_pkg::payload_beat_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] fill_level;
    logic        mem_empty;
    logic        mem_full;
    logic        wr_en;
    logic        load_out;
    logic        bypass;

    assign fill_level = wr_ptr - rd_ptr;
    assign mem_empty  = (wr_ptr == rd_ptr);
    assign mem_full   = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign in_ready   = !mem_full;
    assign wr_en      = in_valid && in_ready;
    assign load_out   = !out_valid || out_ready;
    // Straight into the output register when nothing is queued
    assign bypass     = load_out && mem_empty && wr_en;

    always_ff @(posedge clk) begin
        if (wr_en && !bypass) begin
            mem[wr_ptr[AW-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            if (!mem_empty) begin
                out_beat <= mem[rd_ptr[AW-1:0]];
            end else if (bypass) begin
                out_beat <= in_beat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_out) begin
                if (!mem_empty) begin
                    rd_ptr    <= rd_ptr + 1'b1;
                    out_valid <= 1'b1;
                end else begin
                    out_valid <= wr_en;
                end
            end
        end
    end

    // Storage never holds more than DEPTH beats
    a_fill_bounded: assert property (
        @(posedge clk) disable iff (rst)
        fill_level <= DEPTH
    );

    // Queued beats always have one showing at the output
    a_queued_shows: assert property (
        @(posedge clk) disable iff (rst)
        !mem_empty |-> out_valid
    );

endmodule

`default_nettype wire

//--- hdl/udp_port_filter.sv
//////////////////////////////////////////////////////////////////////
// Keep/drop decision is made once per header and held until last beat
// Payload must not start before its header is accepted
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_macros.svh"

module udp_port_filter (
    input  logic                           clk,
    input  logic                           rst,

    input  udp_hdr_pkg::udp_rx_hdr_t       rx_hdr,
    input  logic                           rx_hdr_valid,
    output logic                           rx_hdr_ready,
    input  echo_stream_pkg::payload_beat_t rx_pay,
    input  logic                           rx_pay_valid,
    output logic                           rx_pay_ready,

    output udp_hdr_pkg::udp_rx_hdr_t       keep_hdr,
    output logic                           keep_hdr_valid,
    input  logic                           keep_hdr_ready,
    output echo_stream_pkg::payload_beat_t keep_pay,
    output logic                           keep_pay_valid,
    input  logic                           keep_pay_ready
);

    echo_stream_pkg::filter_state_t state;
    logic                           is_echo;

    assign is_echo = (rx_hdr.dst_port == `ECHO_PORT);

    // Header side, only open between frames
    assign keep_hdr       = rx_hdr;
    assign keep_hdr_valid = (state == echo_stream_pkg::IDLE) && rx_hdr_valid && is_echo;
    assign rx_hdr_ready   = (state == echo_stream_pkg::IDLE) && (!is_echo || keep_hdr_ready);

    // Payload side, passed through or swallowed
    assign keep_pay       = rx_pay;
    assign keep_pay_valid = (state == echo_stream_pkg::KEEP) && rx_pay_valid;
    assign rx_pay_ready   = (state == echo_stream_pkg::DROP) ||
                            ((state == echo_stream_pkg::KEEP) && keep_pay_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= echo_stream_pkg::IDLE;
        end else begin
            case (state)
                echo_stream_pkg::IDLE: begin
                    if (rx_hdr_valid && rx_hdr_ready) begin
                        state <= is_echo ? echo_stream_pkg::KEEP : echo_stream_pkg::DROP;
                    end
                end
                default: begin
                    // Frame ends with its last beat
                    if (rx_pay_valid && rx_pay_ready && rx_pay.last) begin
                        state <= echo_stream_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // Receive header held steady until it is accepted
    a_rx_hdr_held: assert property (
        @(posedge clk) disable iff (rst)
        (rx_hdr_valid && !rx_hdr_ready) |=> (rx_hdr_valid && $stable(rx_hdr))
    );

    // Accepting a kept header always leads into KEEP
    a_keep_follows_hdr: assert property (
        @(posedge clk) disable iff (rst)
        (keep_hdr_valid && keep_hdr_ready) |=> (state == echo_stream_pkg::KEEP)
    );

endmodule

`default_nettype wire

//--- hdl/echo_stream_pkg.sv
//////////////////////////////////////////////////////////////////////
// Byte-wide payload stream types and the filter FSM encoding
//////////////////////////////////////////////////////////////////////

`default_nettype none

package echo_stream_pkg;

    typedef logic [7:0] byte_t;

    // One payload byte with end-of-frame and error marks
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } payload_beat_t;

    // Payload handling of the frame in progress
    typedef enum logic [1:0] {
        IDLE,
        KEEP,
        DROP
    } filter_state_t;

endpackage

`default_nettype wire

//--- hdl/udp_hdr_pkg.sv
//////////////////////////////////////////////////////////////////////
// UDP/IP header fields as seen at the parsed-frame level
// Ethernet and IP-only fields are not carried
//////////////////////////////////////////////////////////////////////

`default_nettype none

package udp_hdr_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ttl_t;

    // Header of a received datagram
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } udp_rx_hdr_t;

    // Header of an outgoing datagram, checksum 0 means not computed
    typedef struct packed {
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        ttl_t        ttl;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        udp_len_t    length;
        logic [15:0] checksum;
    } udp_tx_hdr_t;

endpackage

`default_nettype wire

//--- include/udp_echo_macros.svh
//////////////////////////////////////////////////////////////////////
// Fixed configuration of the UDP echo core, set at compile time
// FIFO depth must be a power of two
//////////////////////////////////////////////////////////////////////

`ifndef UDP_ECHO_MACROS_SVH
`define UDP_ECHO_MACROS_SVH

// UDP destination port that is answered
`define ECHO_PORT 16'd1234

// Own IPv4 address, 192.168.1.128
`define LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// TTL placed in every reply
`define REPLY_TTL 8'd64

// Payload FIFO depth in beats
`define PAYLOAD_FIFO_DEPTH 64

`endif
